// ==== common/seq_pkg.sv ====
`default_nettype none

package seq_pkg;

    // ------------------------------
    // Widths and timing
    // ------------------------------
    localparam int unsigned addr_width = 8;      // PC and ROM address
    localparam int unsigned data_width = 16;     // One instruction word
    localparam int unsigned imm_width  = 12;     // Immediate field

    // 16 MHz / 1.6M = 10 steps per second
    localparam int unsigned step_period_default = 1_600_000;

    // ------------------------------
    // Instruction format
    // ------------------------------
    typedef enum logic [3:0] {
        op_nop  = 4'h0,     // Just advance
        op_out  = 4'h1,     // Load output register
        op_jmp  = 4'h2,     // Load PC from immediate
        op_halt = 4'hf      // Stop until reset
    } op_e;

    typedef struct packed {
        op_e                  op;     // Upper nibble
        logic [imm_width-1:0] imm;    // Lower 12 bits
    } instr_t;

    // PC control, strobes valid only in a step cycle
    typedef struct packed {
        logic                  load;  // Wins over inc
        logic                  inc;
        logic [addr_width-1:0] addr;  // Jump target
    } pc_ctrl_t;

    // ------------------------------
    // Program image
    // ------------------------------
    localparam int unsigned program_len = 8;

    localparam instr_t program_table [program_len] = '{
        '{op_out,  12'h0a5},    // 0
        '{op_nop,  12'h000},    // 1
        '{op_out,  12'h5a0},    // 2
        '{op_jmp,  12'h006},    // 3  skip over 4 and 5
        '{op_out,  12'hfff},    // 4  never reached
        '{op_nop,  12'h000},    // 5
        '{op_out,  12'h123},    // 6
        '{op_halt, 12'h000}     // 7
    };

endpackage

`default_nettype wire

// ==== program_counter/program_counter.sv ====
`default_nettype none

// Fetch address register
module program_counter import seq_pkg::*; (
    input  logic                  pin3_clk_16mhz,
    input  logic                  arst_n,
    input  pc_ctrl_t              ctrl,       // From sequencer
    output logic [addr_width-1:0] pc          // To ROM and pins
);

    // ------------------------------
    // Address register
    // ------------------------------
    // Load first, then increment, else hold
    always_ff @(posedge pin3_clk_16mhz or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;                   // Start of program
        end else if (ctrl.load) begin
            pc <= ctrl.addr;            // Jump
        end else if (ctrl.inc) begin
            pc <= pc + 1'b1;            // Wraps at 255, ROM halts anyway
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Sequencer decodes exactly one action per step, never both
    a_one_strobe : assert property (
        @(posedge pin3_clk_16mhz) disable iff (!arst_n)
        !(ctrl.load && ctrl.inc)
    );

endmodule

`default_nettype wire

// ==== logic/step_gen.sv ====
`default_nettype none

// Step pulse source, auto tick or manual button
module step_gen import seq_pkg::*; #(
    parameter int unsigned step_period = step_period_default
) (
    input  logic pin3_clk_16mhz,
    input  logic arst_n,
    input  logic auto_run,          // 1 = divided tick, 0 = button
    input  logic step_btn,          // Raw, asynchronous
    output logic step,              // One cycle wide
    output logic heartbeat          // Flips per step
);

    typedef logic [$clog2(step_period)-1:0] cnt_t;

    cnt_t tick_cnt;
    logic tick;
    logic btn_s1, btn_s2, btn_s3;   // Sync chain plus history
    logic btn_rise;

    // ------------------------------
    // Auto-run divider
    // ------------------------------
    // Held at zero while in manual mode, so the first tick
    // lands step_period cycles after auto_run rises
    assign tick = auto_run && (tick_cnt == cnt_t'(step_period - 1));

    always_ff @(posedge pin3_clk_16mhz or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
        end else if (!auto_run || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Button sync and edge
    // ------------------------------
    always_ff @(posedge pin3_clk_16mhz or negedge arst_n) begin
        if (!arst_n) begin
            btn_s1 <= 1'b0;
            btn_s2 <= 1'b0;
            btn_s3 <= 1'b0;
        end else begin
            btn_s1 <= step_btn;         // May go metastable
            btn_s2 <= btn_s1;           // Safe copy
            btn_s3 <= btn_s2;           // Previous level
        end
    end

    assign btn_rise = btn_s2 && !btn_s3;

    // Registered pulse, 3 cycles after the pin edge
    always_ff @(posedge pin3_clk_16mhz or negedge arst_n) begin
        if (!arst_n) begin
            step      <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            step      <= auto_run ? tick : btn_rise;
            heartbeat <= heartbeat ^ step;
        end
    end

    // Sequencer relies on isolated steps
    a_step_single : assert property (
        @(posedge pin3_clk_16mhz) disable iff (!arst_n)
        step |=> !step
    );

endmodule

`default_nettype wire

// ==== logic/program_rom.sv ====
`default_nettype none

// Read-only program store, combinational
module program_rom import seq_pkg::*; (
    input  logic [addr_width-1:0] addr,     // Current PC
    output instr_t                instr     // Same-cycle data
);

    logic [data_width-1:0] rom_word;        // Raw 16-bit word

    // ------------------------------
    // Lookup
    // ------------------------------
    // Past the end of the table reads as halt, so a PC that runs
    // off the program parks instead of executing garbage
    always_comb begin
        if (addr < program_len) begin
            rom_word = program_table[addr[$clog2(program_len)-1:0]];
        end else begin
            rom_word = {op_halt, {imm_width{1'b0}}};
        end
    end

    assign instr = instr_t'(rom_word);      // Split into fields

endmodule

`default_nettype wire

// ==== logic/sequencer.sv ====
`default_nettype none

// Decode and execute, one instruction per step pulse
module sequencer import seq_pkg::*; (
    input  logic                 pin3_clk_16mhz,
    input  logic                 arst_n,
    input  logic                 step,      // From step_gen
    input  instr_t               instr,     // From ROM at current PC
    output pc_ctrl_t             pc_ctrl,   // To program_counter
    output logic [imm_width-1:0] out_reg,   // Board LEDs
    output logic                 halted
);

    logic active;       // This cycle executes
    logic do_out;       // Output register write
    logic do_halt;      // Enter halted state

    assign active = step && !halted;    // Steps ignored once halted

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb begin
        pc_ctrl.load = 1'b0;
        pc_ctrl.inc  = 1'b0;
        pc_ctrl.addr = instr.imm[addr_width-1:0];   // Only used by jmp
        do_out       = 1'b0;
        do_halt      = 1'b0;
        if (active) begin
            case (instr.op)
                op_nop: begin
                    pc_ctrl.inc = 1'b1;
                end
                op_out: begin
                    pc_ctrl.inc = 1'b1;
                    do_out      = 1'b1;
                end
                op_jmp: begin
                    pc_ctrl.load = 1'b1;    // Low 8 bits of imm
                end
                op_halt: begin
                    do_halt = 1'b1;         // PC stays put
                end
                default: begin
                    do_halt = 1'b1;         // Unknown opcode, stop
                end
            endcase
        end
    end

    // ------------------------------
    // Execute
    // ------------------------------
    always_ff @(posedge pin3_clk_16mhz or negedge arst_n) begin
        if (!arst_n) begin
            out_reg <= '0;
            halted  <= 1'b0;
        end else begin
            if (do_out) begin
                out_reg <= instr.imm;   // Visible one cycle after step
            end
            if (do_halt) begin
                halted <= 1'b1;         // Sticky until reset
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Halted never clears and the PC never moves afterwards
    a_halt_sticky : assert property (
        @(posedge pin3_clk_16mhz) disable iff (!arst_n)
        halted |=> halted && !(pc_ctrl.load || pc_ctrl.inc)
    );

endmodule

`default_nettype wire

// ==== logic/top.sv ====
`default_nettype none

// TinyFPGA board top, sequencer and pin map
module top import seq_pkg::*; #(
    parameter int unsigned step_period = step_period_default
) (
    output logic pin1_usb_dp,       // USB pull-up, held off
    output logic pin2_usb_dn,
    input  logic pin3_clk_16mhz,    // On-board oscillator
    input  logic arst_n,
    output logic pin4,              // out_reg[0]
    output logic pin5,
    output logic pin6,
    output logic pin7,
    output logic pin8,
    output logic pin9,
    output logic pin10,
    output logic pin11,
    output logic pin12,
    output logic pin13,
    output logic pin14_sdo,
    output logic pin15_sdi,         // out_reg[11]
    output logic pin16_sck,         // pc[0]
    output logic pin17_ss,
    output logic pin18,
    output logic pin19,             // pc[3]
    input  logic pin20,             // Auto-run select
    input  logic pin21,             // Manual step button
    output logic pin23,             // Halted
    output logic pin24              // Heartbeat
);

    logic                  step;
    logic                  heartbeat;
    logic                  halted;
    logic [addr_width-1:0] pc;
    logic [imm_width-1:0]  out_reg;
    instr_t                instr;
    pc_ctrl_t              pc_ctrl;

    // ------------------------------
    // Blocks
    // ------------------------------
    step_gen #(
        .step_period(step_period)
    ) u_step_gen (
        .pin3_clk_16mhz(pin3_clk_16mhz),
        .arst_n        (arst_n),
        .auto_run      (pin20),
        .step_btn      (pin21),
        .step          (step),
        .heartbeat     (heartbeat)
    );

    program_counter u_pc (
        .pin3_clk_16mhz(pin3_clk_16mhz),
        .arst_n        (arst_n),
        .ctrl          (pc_ctrl),
        .pc            (pc)
    );

    program_rom u_rom (
        .addr (pc),
        .instr(instr)
    );

    sequencer u_seq (
        .pin3_clk_16mhz(pin3_clk_16mhz),
        .arst_n        (arst_n),
        .step          (step),
        .instr         (instr),
        .pc_ctrl       (pc_ctrl),
        .out_reg       (out_reg),
        .halted        (halted)
    );

    // ------------------------------
    // Pin routing
    // ------------------------------
    assign {pin15_sdi, pin14_sdo, pin13, pin12, pin11, pin10,
            pin9, pin8, pin7, pin6, pin5, pin4} = out_reg;

    assign {pin19, pin18, pin17_ss, pin16_sck} = pc[3:0];  // Low nibble only

    assign pin23 = halted;
    assign pin24 = heartbeat;

    assign pin1_usb_dp = 1'b0;      // USB unused
    assign pin2_usb_dn = 1'b0;

endmodule

`default_nettype wire

// ==== tests/tb_checks.svh ====
`ifndef tb_checks_svh
`define tb_checks_svh

// ------------------------------
// Error counting
// ------------------------------
int unsigned errors       = 0;      // All failed checks
int unsigned tests_run    = 0;
int unsigned tests_failed = 0;
int unsigned errors_at_start = 0;   // Snapshot at test start

task automatic begin_test();
    errors_at_start = errors;
endtask

// One line per finished test
task automatic end_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
        tests_failed++;
        $display("Test %-16s failed, %0d bad checks", name, errors - errors_at_start);
    end else begin
        $display("Test %-16s ok", name);
    end
endtask

// ------------------------------
// Typed compares
// ------------------------------
task automatic check_out(input logic [imm_width-1:0] got, input logic [imm_width-1:0] exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t output register: got %03h, expected %03h", $time, got, exp);
    end
endtask

task automatic check_pc(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t PC low nibble: got %0d, expected %0d", $time, got, exp);
    end
endtask

task automatic check_halted(input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t halted: got %b, expected %b", $time, got, exp);
    end
endtask

task automatic check_heartbeat(input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR t=%0t heartbeat: got %b, expected %b", $time, got, exp);
    end
endtask

`endif

// ==== tests/tb_top.sv ====
`default_nettype none

module tb_top import seq_pkg::*; ();

    localparam int unsigned tb_step_period = 20;     // Short auto tick for sim
    localparam int unsigned auto_cycles    = 200;
    localparam int unsigned timeout_cycles = 2000;   // Full run needs about 650

    // Model state after n step pulses
    typedef struct packed {
        logic [imm_width-1:0]  out;
        logic [addr_width-1:0] pc;
        logic                  halted;
        logic                  heartbeat;
    } expect_t;

    logic pin3_clk_16mhz;
    logic arst_n;
    logic pin20;                        // Auto-run select
    logic pin21;                        // Step button
    wire  [imm_width-1:0] out_pins;
    wire  [3:0]           pc_pins;
    wire  [1:0]           usb_pins;
    wire                  halted_pin;
    wire                  heartbeat_pin;

    int unsigned cycles  = 0;
    logic        saw_fff = 1'b0;        // Skipped word ever shown

    `include "tb_checks.svh"

    top #(.step_period(tb_step_period)) dut0 (
        .pin1_usb_dp(usb_pins[0]),     .pin2_usb_dn(usb_pins[1]),
        .pin3_clk_16mhz(pin3_clk_16mhz), .arst_n(arst_n),
        .pin4(out_pins[0]),            .pin5(out_pins[1]),
        .pin6(out_pins[2]),            .pin7(out_pins[3]),
        .pin8(out_pins[4]),            .pin9(out_pins[5]),
        .pin10(out_pins[6]),           .pin11(out_pins[7]),
        .pin12(out_pins[8]),           .pin13(out_pins[9]),
        .pin14_sdo(out_pins[10]),      .pin15_sdi(out_pins[11]),
        .pin16_sck(pc_pins[0]),        .pin17_ss(pc_pins[1]),
        .pin18(pc_pins[2]),            .pin19(pc_pins[3]),
        .pin20(pin20),                 .pin21(pin21),
        .pin23(halted_pin),            .pin24(heartbeat_pin)
    );

    always #50 pin3_clk_16mhz = ~pin3_clk_16mhz;    // 100 unit period

    // ------------------------------
    // Watchdogs
    // ------------------------------
    always @(posedge pin3_clk_16mhz) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: run still going after %0d cycles, stopping", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(negedge pin3_clk_16mhz) begin
        if (arst_n && out_pins == 12'hfff) saw_fff <= 1'b1;  // Address 4 executed
    end

    // Walk the program table for n pulses
    function automatic expect_t expected_after(input int unsigned n);
        expect_t e;
        instr_t  ins;
        e = '0;
        for (int unsigned i = 0; i < n; i++) begin
            e.heartbeat = ~e.heartbeat;             // Every pulse, halted or not
            if (!e.halted) begin
                if (e.pc < addr_width'(program_len)) begin
                    ins = program_table[e.pc[$clog2(program_len)-1:0]];
                end else begin
                    ins.op  = op_halt;              // Past the table
                    ins.imm = '0;
                end
                case (ins.op)
                    op_out: begin
                        e.out = ins.imm;
                        e.pc  = e.pc + 1'b1;
                    end
                    op_nop: begin
                        e.pc = e.pc + 1'b1;
                    end
                    op_jmp: begin
                        e.pc = ins.imm[addr_width-1:0];
                    end
                    default: begin
                        e.halted = 1'b1;
                    end
                endcase
            end
        end
        return e;
    endfunction

    task automatic check_state(input expect_t e);
        check_out(out_pins, e.out);
        check_pc(pc_pins, e.pc[3:0]);
        check_halted(halted_pin, e.halted);
        check_heartbeat(heartbeat_pin, e.heartbeat);
    endtask

    task automatic apply_reset();
        @(posedge pin3_clk_16mhz);
        arst_n <= 1'b0;
        repeat (10) @(posedge pin3_clk_16mhz);
        arst_n <= 1'b1;
    endtask

    // Press, release, sample 8 cycles after the press
    task automatic pulse_button();
        @(posedge pin3_clk_16mhz);
        pin21 <= 1'b1;
        repeat (6) @(posedge pin3_clk_16mhz);
        pin21 <= 1'b0;
        repeat (2) @(posedge pin3_clk_16mhz);
        @(negedge pin3_clk_16mhz);
    endtask

    task automatic rest_gap();
        int unsigned gap;
        gap = 6 + ($urandom % 15);                  // 6 to 20 cycles
        repeat (4 + gap) @(posedge pin3_clk_16mhz);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        expect_t e;
        pin3_clk_16mhz = 1'b0;
        arst_n         = 1'b0;
        pin20          = 1'b0;
        pin21          = 1'b0;
        void'($urandom(32'h2734));

        begin_test();
        apply_reset();
        @(negedge pin3_clk_16mhz);
        check_state(expected_after(0));
        if (usb_pins !== 2'b00) begin
            errors++;
            $display("ERROR t=%0t USB pins: got %b, expected 00", $time, usb_pins);
        end
        end_test("reset");

        begin_test();
        for (int unsigned n = 1; n <= 4; n++) begin  // out, nop, out, jmp
            pulse_button();
            check_state(expected_after(n));
            rest_gap();
        end
        end_test("manual stepping");

        begin_test();
        e = expected_after(4);
        check_pc(pc_pins, e.pc[3:0]);               // Landed on the jump target
        end_test("jump");

        begin_test();
        for (int unsigned n = 5; n <= 9; n++) begin  // Halt at 6, then 3 ignored
            pulse_button();
            check_state(expected_after(n));
            rest_gap();
        end
        end_test("halt");

        // Whole manual program has run, address 4 must never have shown
        begin_test();
        if (saw_fff) begin
            errors++;
            $display("Output register showed 0xFFF, the jump did not skip address 4");
        end
        end_test("jump skip");

        begin_test();
        apply_reset();
        @(posedge pin3_clk_16mhz);
        pin20 <= 1'b1;
        repeat (auto_cycles) @(posedge pin3_clk_16mhz);
        pin20 <= 1'b0;
        repeat (4) @(posedge pin3_clk_16mhz);     // Let the last tick execute
        @(negedge pin3_clk_16mhz);
        check_state(expected_after(auto_cycles / tb_step_period));
        end_test("auto-run");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
common/seq_pkg.sv
program_counter/program_counter.sv
logic/step_gen.sv
logic/program_rom.sv
logic/sequencer.sv
logic/top.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= -sv --timing --assert
TOP       ?= tb_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	-./$(OBJ_DIR)/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
